// ==== source/accel_params_pkg.sv ====
`default_nettype none

package accel_params_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Matrix shape
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Rows also give the length of the input vector
  localparam int NUM_ROWS = 4;
  // One output per column
  localparam int NUM_COLS = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DATA_WIDTH    = 8;
  // Holds 4 * 255 * 255 = 260100 without overflow
  localparam int ACC_WIDTH     = 18;
  localparam int WEIGHT_DEPTH  = NUM_ROWS * NUM_COLS;
  localparam int WEIGHT_ADDR_W = $clog2(WEIGHT_DEPTH);
  localparam int ROW_W         = $clog2(NUM_ROWS);
  localparam int COL_W         = $clog2(NUM_COLS);

  // Read latencies of the source memory and of the column memories
  localparam int SRC_RD_LATENCY = 1;
  localparam int COL_RD_LATENCY = 0;

endpackage

`default_nettype wire

// ==== source/accel_types_pkg.sv ====
`default_nettype none

package accel_types_pkg;

  import accel_params_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scalar types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [ACC_WIDTH-1:0]     acc_t;
  typedef logic [WEIGHT_ADDR_W-1:0] waddr_t;
  typedef logic [ROW_W-1:0]         row_t;
  typedef logic [COL_W-1:0]         col_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Vectors and bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Element r of the input vector multiplies row r of the matrix
  typedef data_t [NUM_ROWS-1:0] x_vec_t;
  typedef acc_t  [NUM_COLS-1:0] y_vec_t;
  // One read word per column memory, all at the same row
  typedef data_t [NUM_COLS-1:0] col_dout_t;

  // Host write port into the source weight memory
  typedef struct packed {
    logic   en;
    waddr_t addr;
    data_t  data;
  } weight_wr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State machines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {LD_IDLE, LD_COPY, LD_DONE} loader_state_t;

  typedef enum logic [1:0] {MAC_IDLE, MAC_RUN, MAC_DONE} mac_state_t;

endpackage

`default_nettype wire

// ==== source/bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bram import accel_types_pkg::*; #(
  parameter int DEPTH      = 16,
  parameter int RD_LATENCY = 1
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     wr_en,
  input  wire [$clog2(DEPTH)-1:0] wr_addr,
  input  wire data_t              wr_data,
  input  wire                     rd_en,
  input  wire [$clog2(DEPTH)-1:0] rd_addr,
  output data_t                   rd_data
);

  data_t mem [DEPTH];
  data_t rd_word;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // A read of the address being written sees the new word
  assign rd_word = (wr_en && (wr_addr == rd_addr)) ? wr_data : mem[rd_addr];

  if (RD_LATENCY == 0) begin : g_comb_rd
    assign rd_data = rd_en ? rd_word : '0;
  end else begin : g_reg_rd
    // Output register only moves on an enabled read
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_data <= '0;
      end else if (rd_en) begin
        rd_data <= rd_word;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/weight_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_loader import accel_params_pkg::*, accel_types_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             w_valid,
  output logic            w_ready,
  output logic            src_rd_en,
  output waddr_t          src_rd_addr,
  input  wire data_t      src_rd_data,
  input  wire row_t       col_rd_row,
  output col_dout_t       col_dout
);

  loader_state_t       state;

  // Destination of the word coming back from the source memory
  logic                wr_vld_q;
  row_t                wr_row_q;
  col_t                wr_col_q;

  logic [NUM_COLS-1:0] col_wr_en;
  logic                last_wr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Copy FSM and read address counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= LD_IDLE;
      src_rd_en   <= 1'b0;
      src_rd_addr <= '0;
      w_ready     <= 1'b0;
    end else begin
      case (state)
        LD_IDLE: begin
          if (w_valid) begin
            state       <= LD_COPY;
            src_rd_en   <= 1'b1;
            src_rd_addr <= '0;
          end
        end
        LD_COPY: begin
          if (!w_valid) begin
            // Host gave up on this load
            state     <= LD_IDLE;
            src_rd_en <= 1'b0;
          end else begin
            if (src_rd_en) begin
              if (src_rd_addr == waddr_t'(WEIGHT_DEPTH - 1)) begin
                src_rd_en <= 1'b0;
              end else begin
                src_rd_addr <= src_rd_addr + 1'b1;
              end
            end
            if (last_wr) begin
              state <= LD_DONE;
            end
          end
        end
        LD_DONE: begin
          // Ready holds as long as the host keeps w_valid up
          if (w_valid) begin
            w_ready <= 1'b1;
          end else begin
            w_ready <= 1'b0;
            state   <= LD_IDLE;
          end
        end
        default: begin
          state <= LD_IDLE;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scatter into the column memories
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Source data lags the read by one cycle, so the destination is delayed with it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_vld_q <= 1'b0;
      wr_row_q <= '0;
      wr_col_q <= '0;
    end else begin
      wr_vld_q <= src_rd_en;
      wr_row_q <= row_t'(src_rd_addr / NUM_COLS);
      wr_col_q <= col_t'(src_rd_addr % NUM_COLS);
    end
  end

  assign last_wr = wr_vld_q && (wr_row_q == row_t'(NUM_ROWS - 1)) &&
                   (wr_col_q == col_t'(NUM_COLS - 1));

  for (genvar c = 0; c < NUM_COLS; c++) begin : g_col_mem
    // Only the memory of the word's own column takes the write
    assign col_wr_en[c] = wr_vld_q && (wr_col_q == col_t'(c));

    bram #(
      .DEPTH      (NUM_ROWS),
      .RD_LATENCY (COL_RD_LATENCY)
    ) u_col_mem (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (col_wr_en[c]),
      .wr_addr (wr_row_q),
      .wr_data (src_rd_data),
      .rd_en   (1'b1),
      .rd_addr (col_rd_row),
      .rd_data (col_dout[c])
    );
  end

endmodule

`default_nettype wire

// ==== source/column_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module column_mac import accel_params_pkg::*, accel_types_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            start,
  input  wire x_vec_t    x_in,
  input  wire            weights_ready,
  output row_t           col_rd_row,
  input  wire col_dout_t col_dout,
  output y_vec_t         y_out,
  output logic           busy,
  output logic           done
);

  mac_state_t state;
  x_vec_t     x_q;
  row_t       row_q;
  data_t      x_sel;
  logic       accept;

  // A start outside idle, or before weights are loaded, is dropped
  assign accept = (state == MAC_IDLE) && start && weights_ready;

  assign col_rd_row = row_q;
  assign x_sel      = x_q[row_q];
  assign busy       = (state != MAC_IDLE);

  always_ff @(posedge clk) begin
    if (accept) begin
      x_q <= x_in;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Row sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= MAC_IDLE;
      row_q <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        MAC_IDLE: begin
          if (accept) begin
            state <= MAC_RUN;
            row_q <= '0;
          end
        end
        MAC_RUN: begin
          if (row_q == row_t'(NUM_ROWS - 1)) begin
            state <= MAC_DONE;
            row_q <= '0;
          end else begin
            row_q <= row_q + 1'b1;
          end
        end
        MAC_DONE: begin
          // Results are final here, flag them one cycle later
          done  <= 1'b1;
          state <= MAC_IDLE;
        end
        default: begin
          state <= MAC_IDLE;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Column accumulators
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Every column adds W[row][c] * x[row] in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      y_out <= '0;
    end else if (accept) begin
      y_out <= '0;
    end else if (state == MAC_RUN) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        y_out[c] <= y_out[c] + acc_t'(col_dout[c]) * acc_t'(x_sel);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/weight_mvm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_mvm_top import accel_params_pkg::*, accel_types_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire weight_wr_t host_wr,
  input  wire             w_valid,
  output logic            w_ready,
  input  wire             start,
  input  wire x_vec_t     x_in,
  output logic            busy,
  output logic            done,
  output y_vec_t          y_out
);

  // Loader side of the source memory
  logic      src_rd_en;
  waddr_t    src_rd_addr;
  data_t     src_rd_data;

  // Shared row read of the column memories
  row_t      col_rd_row;
  col_dout_t col_dout;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Source weight memory, written by the host
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  bram #(
    .DEPTH      (WEIGHT_DEPTH),
    .RD_LATENCY (SRC_RD_LATENCY)
  ) u_src_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (host_wr.en),
    .wr_addr (host_wr.addr),
    .wr_data (host_wr.data),
    .rd_en   (src_rd_en),
    .rd_addr (src_rd_addr),
    .rd_data (src_rd_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Loader and MAC
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  weight_loader u_weight_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .src_rd_en   (src_rd_en),
    .src_rd_addr (src_rd_addr),
    .src_rd_data (src_rd_data),
    .col_rd_row  (col_rd_row),
    .col_dout    (col_dout)
  );

  // The MAC may only start once the loader reports a complete matrix
  column_mac u_column_mac (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .x_in          (x_in),
    .weights_ready (w_ready),
    .col_rd_row    (col_rd_row),
    .col_dout      (col_dout),
    .y_out         (y_out),
    .busy          (busy),
    .done          (done)
  );

endmodule

`default_nettype wire

// ==== testbench/weight_mvm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_mvm_tb import accel_params_pkg::*, accel_types_pkg::*;;

  localparam int          CLK_PERIOD   = 100;
  localparam int          DRIVE_DLY    = 5;
  localparam int          RESET_CYCLES = 5;
  // First edge that samples w_valid to w_ready high
  localparam int          LOAD_CYCLES  = WEIGHT_DEPTH + 2;
  // Start edge to done pulse
  localparam int          DONE_CYCLES  = NUM_ROWS + 1;
  localparam logic [31:0] RAND_SEED    = 32'h8540_d448;
  localparam string       STIM_FILE    = "testbench/weight_mvm_stim.txt";

  typedef data_t [WEIGHT_DEPTH-1:0] w_mat_t;

  logic       clk;
  logic       rst_n;
  weight_wr_t host_wr;
  logic       w_valid;
  logic       w_ready;
  logic       start;
  x_vec_t     x_in;
  logic       busy;
  logic       done;
  y_vec_t     y_out;

  // Records from the stimulus file
  logic [8*16-1:0] name_q[$];
  logic            reuse_q[$];
  w_mat_t          w_q[$];
  x_vec_t          x_q[$];
  y_vec_t          y_q[$];
  logic            records_loaded;
  logic [8*16-1:0] cur_test;

  weight_mvm_top u_weight_mvm_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .host_wr (host_wr),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .start   (start),
    .x_in    (x_in),
    .busy    (busy),
    .done    (done),
    .y_out   (y_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Failure handling and compares
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %0s %0s expected %0b actual %0b", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  task automatic check_y(input y_vec_t exp, input y_vec_t act);
    for (int c = 0; c < NUM_COLS; c++) begin
      if (exp[c] !== act[c]) begin
        $display("FAILED %0s y_out[%0d] expected %0h actual %0h", cur_test, c, exp[c], act[c]);
        stop_run();
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus file
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic read_hex(input int fd, output logic [31:0] val);
    int n;
    n = $fscanf(fd, "%h", val);
    if (n != 1) begin
      $display("A stimulus record is incomplete");
      stop_run();
    end
  endtask

  task automatic read_stim();
    int              fd;
    int              n;
    logic [8*16-1:0] tok;
    logic [8*256-1:0] rest;
    logic [31:0]     val;
    w_mat_t          w;
    x_vec_t          x;
    y_vec_t          y;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %0s", STIM_FILE);
      stop_run();
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        break;
      end
      if (tok == "#") begin
        n = $fgets(rest, fd);
      end else begin
        name_q.push_back(tok);
        read_hex(fd, val);
        reuse_q.push_back(val[0]);
        for (int a = 0; a < WEIGHT_DEPTH; a++) begin
          read_hex(fd, val);
          w[a] = data_t'(val);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
          read_hex(fd, val);
          x[r] = data_t'(val);
        end
        for (int c = 0; c < NUM_COLS; c++) begin
          read_hex(fd, val);
          y[c] = acc_t'(val);
        end
        w_q.push_back(w);
        x_q.push_back(x);
        y_q.push_back(y);
      end
    end
    $fclose(fd);
    if (name_q.size() == 0) begin
      $display("The stimulus file holds no records");
      stop_run();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus actions that start and end at a drive point
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic tick();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic idle_cycles();
    int n;
    n = $urandom % 4;
    repeat (n) tick();
  endtask

  task automatic write_matrix(input w_mat_t w);
    for (int a = 0; a < WEIGHT_DEPTH; a++) begin
      host_wr.en   = 1'b1;
      host_wr.addr = waddr_t'(a);
      host_wr.data = w[a];
      tick();
    end
    host_wr = '0;
  endtask

  task automatic load_matrix();
    w_valid = 1'b1;
    // Ready must stay low until the exact load cycle
    for (int k = 1; k <= LOAD_CYCLES + 1; k++) begin
      tick();
      check_bit("w_ready during load", k > LOAD_CYCLES, w_ready);
    end
  endtask

  task automatic unload();
    w_valid = 1'b0;
    tick();
    check_bit("w_ready after w_valid fall", 1'b0, w_ready);
    // Without loaded weights this pulse must be dropped
    start = 1'b1;
    x_in  = '1;
    tick();
    start = 1'b0;
    check_bit("busy after dropped start", 1'b0, busy);
  endtask

  task automatic run_vector(input x_vec_t x, input y_vec_t exp);
    start = 1'b1;
    x_in  = x;
    for (int k = 1; k <= DONE_CYCLES + 1; k++) begin
      tick();
      if (k == 1) begin
        start = 1'b0;
        x_in  = ~x;
      end
      check_bit("done", k == DONE_CYCLES + 1, done);
      if (k <= DONE_CYCLES) begin
        check_bit("busy", 1'b1, busy);
      end
      check_bit("w_ready held", 1'b1, w_ready);
    end
    check_y(exp, y_out);
    tick();
    check_bit("done pulse width", 1'b0, done);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : main
    clk            = 1'b0;
    rst_n          = 1'b0;
    host_wr        = '0;
    w_valid        = 1'b0;
    start          = 1'b0;
    x_in           = '0;
    records_loaded = 1'b0;
    cur_test       = "reset";
    void'($urandom(RAND_SEED));
    read_stim();
    records_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_bit("w_ready", 1'b0, w_ready);
    check_bit("busy", 1'b0, busy);
    check_bit("done", 1'b0, done);
    check_y('0, y_out);
    for (int i = 0; i < name_q.size(); i++) begin
      cur_test = name_q[i];
      if (!reuse_q[i]) begin
        if (w_valid) begin
          unload();
        end
        write_matrix(w_q[i]);
        load_matrix();
      end else if (!w_valid) begin
        $display("Record %0s reuses a matrix that was never loaded", cur_test);
        stop_run();
      end
      idle_cycles();
      run_vector(x_q[i], y_q[i]);
    end
    $display("Everything OK");
    $finish;
  end

  // Bound on the run that grows with the number of records
  initial begin : watchdog
    wait (records_loaded);
    #((name_q.size() * 60 + 100) * CLK_PERIOD);
    $display("Timeout, the test sequence did not finish in time");
    stop_run();
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/accel_params_pkg.sv
source/accel_types_pkg.sv
source/bram.sv
source/weight_loader.sv
source/column_mac.sv
source/weight_mvm_top.sv
testbench/weight_mvm_tb.sv

// ==== testbench/weight_mvm_stim.txt ====
# test reuse w00..w15 (row-major) x0..x3 y0..y3, all values in hex
# reuse 1 runs the vector on the matrix already loaded and ignores the weight columns
ident 0 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 5a 64 6e 78
unit_x2 1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01 00 09 0a 0b 0c
zero_x 1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0
all_max 0 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 3f804 3f804 3f804 3f804
max_row3 1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ff fe01 fe01 fe01 fe01
mixed 0 03 00 ff 07 12 fe 01 00 00 40 80 c0 05 06 07 08 0a 01 02 10 80 1de b67 246
reload_a 0 10 20 30 40 01 02 03 04 00 00 00 00 80 40 20 10 02 03 07 01 a3 86 89 9c
reload_b 1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ff 01 00 00 ff1 1fe2 2fd3 3fc4
